// ==== hw/umi_endpoint.sv ====
`timescale 1ns/1ns

// turns merged umi requests into local bus cycles, answers reads
module umi_endpoint
  #(parameter int UW = 256,
    parameter int AW = 64,
    parameter int DW = 64)
   (input  logic          clk,
    input  logic          nreset,
    // merged request from the arbiter
    input  logic          arb_valid,
    input  logic [UW-1:0] arb_packet,
    output logic          arb_ready,
    // read response
    output logic          umi0_out_valid,
    output logic [UW-1:0] umi0_out_packet,
    input  logic          umi0_out_ready,
    // local memory bus
    output logic [AW-1:0] loc_addr,   // byte address
    output logic          loc_write,  // one cycle per accepted write
    output logic          loc_read,   // one cycle per accepted read
    output logic [DW-1:0] loc_wrdata,
    input  logic [DW-1:0] loc_rddata, // combinational from device
    input  logic          loc_ready); // low while device busy

   // request fields
   logic [31:0]                      req_cmd;
   logic                             req_write;
   logic [umi_pkg::SIZE_W-1:0]       req_size;
   logic [umi_pkg::OPTIONS_W-1:0]    req_options;
   logic [AW-1:0]                    req_srcaddr;

   // handshake
   logic                             slot_free;
   logic                             xfer;

   // response registers
   logic [DW-1:0]                    data_q;
   logic [AW-1:0]                    dstaddr_q;
   logic [umi_pkg::SIZE_W-1:0]       size_q;
   logic [umi_pkg::OPTIONS_W-1:0]    options_q;

   //####################################################################
   // unpack request
   //####################################################################

   assign req_cmd     = arb_packet[umi_pkg::CMD_MSB:umi_pkg::CMD_LSB];
   assign req_write   = req_cmd[umi_pkg::WRITE_BIT];
   assign req_size    = req_cmd[umi_pkg::SIZE_MSB:umi_pkg::SIZE_LSB];
   assign req_options = req_cmd[umi_pkg::OPTIONS_MSB:umi_pkg::OPTIONS_LSB];
   assign req_srcaddr = arb_packet[umi_pkg::SRC_LSB +: AW];

   assign loc_addr   = arb_packet[umi_pkg::DST_LSB +: AW];  // straight through
   assign loc_wrdata = arb_packet[umi_pkg::DATA_LSB +: DW]; // low DW bits only

   //####################################################################
   // handshake
   //####################################################################

   // response slot frees up in the same cycle it drains
   assign slot_free = ~umi0_out_valid | umi0_out_ready;

   // writes ignore the response slot, reads wait for it
   assign arb_ready = loc_ready & (req_write | slot_free);
   assign xfer      = arb_valid & arb_ready;

   assign loc_write = xfer & req_write;
   assign loc_read  = xfer & ~req_write;

   //####################################################################
   // response valid
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         umi0_out_valid <= 1'b0;
      else if (loc_read)
         umi0_out_valid <= 1'b1; // new read wins over drain of old one
      else if (umi0_out_valid && umi0_out_ready)
         umi0_out_valid <= 1'b0;
   end

   //####################################################################
   // response payload
   //####################################################################

   // captured at the read transfer, held until the next read
   always_ff @(posedge clk)
   begin
      if (loc_read)
      begin
         data_q    <= loc_rddata;
         dstaddr_q <= req_srcaddr; // reply goes back to the requester
         size_q    <= req_size;
         options_q <= req_options;
      end
   end

   // pack response, unused bits stay zero
   always_comb
   begin
      umi0_out_packet = '0;
      umi0_out_packet[umi_pkg::CMD_LSB + umi_pkg::WRITE_BIT] = 1'b1;
      umi0_out_packet[umi_pkg::OPCODE_MSB:umi_pkg::OPCODE_LSB] = umi_pkg::RESP_OPCODE;
      umi0_out_packet[umi_pkg::SIZE_MSB:umi_pkg::SIZE_LSB] = size_q;       // echoed
      umi0_out_packet[umi_pkg::OPTIONS_MSB:umi_pkg::OPTIONS_LSB] = options_q;
      umi0_out_packet[umi_pkg::DST_LSB +: AW] = dstaddr_q;
      umi0_out_packet[umi_pkg::SRC_LSB +: AW] = '0; // endpoint has no address
      umi0_out_packet[umi_pkg::DATA_LSB +: DW] = data_q;
   end

endmodule

// ==== hw/umi_ep_top.sv ====
`timescale 1ns/1ns

// umi memory endpoint, two request channels into one register file
module umi_ep_top
  #(parameter int UW    = umi_pkg::UW,
    parameter int AW    = umi_pkg::AW,
    parameter int DW    = umi_pkg::DW,
    parameter int DEPTH = 64)
   (input  logic          clk,
    input  logic          nreset,
    // write requests
    input  logic          umi0_in_valid,
    input  logic [UW-1:0] umi0_in_packet,
    output logic          umi0_in_ready,
    // read requests
    input  logic          umi1_in_valid,
    input  logic [UW-1:0] umi1_in_packet,
    output logic          umi1_in_ready,
    // read responses
    output logic          umi0_out_valid,
    output logic [UW-1:0] umi0_out_packet,
    input  logic          umi0_out_ready);

   // arbiter to endpoint
   logic          arb_valid;
   logic [UW-1:0] arb_packet;
   logic          arb_ready;

   // local bus
   logic [AW-1:0] loc_addr;
   logic          loc_write;
   logic          loc_read;
   logic [DW-1:0] loc_wrdata;
   logic [DW-1:0] loc_rddata;
   logic          loc_ready;

   //####################################################################
   // request merge, channel 0 in the low slot
   //####################################################################

   umi_mux #(.N(2), .UW(UW))
   mux_i (.clk        (clk),
          .nreset     (nreset),
          .in_valid   ({umi1_in_valid, umi0_in_valid}),
          .in_packet  ({umi1_in_packet, umi0_in_packet}),
          .in_ready   ({umi1_in_ready, umi0_in_ready}),
          .out_valid  (arb_valid),
          .out_packet (arb_packet),
          .out_ready  (arb_ready));

   //####################################################################
   // endpoint and memory
   //####################################################################

   umi_endpoint #(.UW(UW), .AW(AW), .DW(DW))
   ep_i (.clk             (clk),
         .nreset          (nreset),
         .arb_valid       (arb_valid),
         .arb_packet      (arb_packet),
         .arb_ready       (arb_ready),
         .umi0_out_valid  (umi0_out_valid),
         .umi0_out_packet (umi0_out_packet),
         .umi0_out_ready  (umi0_out_ready),
         .loc_addr        (loc_addr),
         .loc_write       (loc_write),
         .loc_read        (loc_read),
         .loc_wrdata      (loc_wrdata),
         .loc_rddata      (loc_rddata),
         .loc_ready       (loc_ready));

   umi_regfile #(.DEPTH(DEPTH), .AW(AW), .DW(DW))
   regfile_i (.clk        (clk),
              .nreset     (nreset),
              .loc_addr   (loc_addr),
              .loc_write  (loc_write),
              .loc_read   (loc_read),
              .loc_wrdata (loc_wrdata),
              .loc_rddata (loc_rddata),
              .loc_ready  (loc_ready));

endmodule

// ==== hw/umi_mux.sv ====
`timescale 1ns/1ns

// round robin merge of N valid/ready packet channels
module umi_mux
  #(parameter int N  = 2,
    parameter int UW = 256)
   (input  logic            clk,
    input  logic            nreset,
    // request channels
    input  logic [N-1:0]    in_valid,
    input  logic [N*UW-1:0] in_packet,
    output logic [N-1:0]    in_ready,
    // merged channel
    output logic            out_valid,
    output logic [UW-1:0]   out_packet,
    input  logic            out_ready);

   localparam int IW = (N > 1) ? $clog2(N) : 1; // channel index width

   logic [IW-1:0] last_q;  // last granted channel
   logic          hold_q;  // grant locked, waiting for ready
   logic [IW-1:0] held_q;  // channel locked in
   logic          rr_found;
   logic [IW-1:0] rr_sel;  // round robin choice
   logic [IW-1:0] sel;     // grant in force this cycle

   //####################################################################
   // round robin pick
   //####################################################################

   // search starts one past the last winner and wraps
   always_comb
   begin
      rr_found = 1'b0;
      rr_sel   = last_q; // no valid input, stay put
      for (int i = 1; i <= N; i++)
      begin
         if (!rr_found && in_valid[(int'(last_q) + i) % N])
         begin
            rr_found = 1'b1;
            rr_sel   = IW'((int'(last_q) + i) % N);
         end
      end
   end

   // stalled grant must not move, packet stays stable
   assign sel = hold_q ? held_q : rr_sel;

   //####################################################################
   // output side
   //####################################################################

   assign out_valid  = in_valid[sel];
   assign out_packet = in_packet[sel*UW +: UW];

   always_comb
   begin
      in_ready      = '0;
      in_ready[sel] = out_ready; // only the winner sees ready
   end

   //####################################################################
   // grant state
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         last_q <= '0;
         hold_q <= 1'b0;
         held_q <= '0;
      end
      else
      begin
         if (out_valid && out_ready)
            last_q <= sel; // pointer moves on transfer only
         hold_q <= out_valid & ~out_ready; // lock while stalled
         held_q <= sel;
      end
   end

endmodule

// ==== hw/umi_pkg.sv ====
// shared packet layout for the umi endpoint
package umi_pkg;

   //####################################################################
   // default widths
   //####################################################################

   localparam int UW = 256; // full packet
   localparam int AW = 64;  // address fields
   localparam int DW = 64;  // data used out of the data field

   //####################################################################
   // command word, packet bits 31:0
   //####################################################################

   localparam int CMD_LSB = 0;
   localparam int CMD_MSB = 31;

   // offsets inside the command word
   localparam int WRITE_BIT   = 0;  // set on writes and responses
   localparam int OPCODE_LSB  = 1;
   localparam int OPCODE_MSB  = 7;  // 7 bit opcode
   localparam int SIZE_LSB    = 8;
   localparam int SIZE_MSB    = 11; // 4 bit size
   localparam int OPTIONS_LSB = 12;
   localparam int OPTIONS_MSB = 31; // 20 bit options

   localparam int OPCODE_W  = OPCODE_MSB - OPCODE_LSB + 1;
   localparam int SIZE_W    = SIZE_MSB - SIZE_LSB + 1;
   localparam int OPTIONS_W = OPTIONS_MSB - OPTIONS_LSB + 1;

   //####################################################################
   // address and data fields
   //####################################################################

   localparam int DST_LSB  = 32;  // destination, AW bits
   localparam int SRC_LSB  = 96;  // source / return address, AW bits
   localparam int DATA_LSB = 160; // data, up to 96 bits, DW used

   //####################################################################
   // response encoding
   //####################################################################

   // opcode carried by read responses
   localparam logic [OPCODE_W-1:0] RESP_OPCODE = 7'd0;

   // word granularity of the local bus
   localparam int WORD_SHIFT = 3; // 8 bytes per word

endpackage

// ==== hw/umi_regfile.sv ====
`timescale 1ns/1ns

// small register file memory on the local bus
module umi_regfile
  #(parameter int DEPTH = 64,
    parameter int AW    = 64,
    parameter int DW    = 64)
   (input  logic          clk,
    input  logic          nreset,
    input  logic [AW-1:0] loc_addr,
    input  logic          loc_write,
    input  logic          loc_read,
    input  logic [DW-1:0] loc_wrdata,
    output logic [DW-1:0] loc_rddata,
    output logic          loc_ready);

   localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // word index width

   logic [DW-1:0] mem [DEPTH]; // contents come up unknown
   logic [IW-1:0] word_idx;
   logic          busy_q;      // one cycle after each write

   // index wraps modulo DEPTH, needs a power of two
   if ((1 << IW) != DEPTH)
   begin : g_depth_check
      $error("umi_regfile DEPTH must be a power of two");
   end

   //####################################################################
   // addressing
   //####################################################################

   // byte address to word index, upper bits dropped
   assign word_idx = loc_addr[umi_pkg::WORD_SHIFT +: IW];

   //####################################################################
   // write port
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (loc_write)
         mem[word_idx] <= loc_wrdata;
   end

   // busy tracks the write just done
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         busy_q <= 1'b0;
      else
         busy_q <= loc_write;
   end

   assign loc_ready = ~busy_q;

   //####################################################################
   // read port
   //####################################################################

   // combinational, zero when no read is asked for
   assign loc_rddata = loc_read ? mem[word_idx] : '0;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the umi endpoint testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module umi_ep_tb -f umi_ep.f -Mdir "$BUILD" -o umi_ep_sim
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

"./$BUILD/umi_ep_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# the log decides, exit status is a second guard
if grep -q "Test FAILED" "$LOG"; then
   echo "simulation reported a failure, see $LOG"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

echo "simulation finished cleanly"
exit 0

// ==== testbench/umi_ep_assertions.sv ====
`timescale 1ns/1ns

// handshake and reset properties on the endpoint top level
module umi_ep_assertions
  #(parameter int UW = 256)
   (input logic          clk,
    input logic          nreset,
    input logic          umi0_in_ready,
    input logic          umi1_in_ready,
    input logic          umi0_out_valid,
    input logic [UW-1:0] umi0_out_packet,
    input logic          umi0_out_ready);

   // stalled response holds valid and payload
   a_out_hold: assert property (@(posedge clk) disable iff (!nreset)
      umi0_out_valid && !umi0_out_ready |=> umi0_out_valid && $stable(umi0_out_packet))
      else $error("response valid or packet moved while stalled");

   // arbiter hands ready to one channel at most
   a_one_ready: assert property (@(posedge clk) disable iff (!nreset)
      !(umi0_in_ready && umi1_in_ready))
      else $error("both request channels see ready");

   // nothing pending right out of reset
   a_reset_idle: assert property (@(posedge clk)
      !$past(nreset) |-> !umi0_out_valid)
      else $error("response valid one cycle after reset");

endmodule

// attach to every endpoint top instance
bind umi_ep_top umi_ep_assertions #(.UW(UW))
   assert_i (.clk             (clk),
             .nreset          (nreset),
             .umi0_in_ready   (umi0_in_ready),
             .umi1_in_ready   (umi1_in_ready),
             .umi0_out_valid  (umi0_out_valid),
             .umi0_out_packet (umi0_out_packet),
             .umi0_out_ready  (umi0_out_ready));

// ==== testbench/umi_ep_tb.sv ====
`timescale 1ns/1ns

// random traffic testbench for the umi memory endpoint
module umi_ep_tb;

   localparam int UW          = umi_pkg::UW;
   localparam int AW          = umi_pkg::AW;
   localparam int DW          = umi_pkg::DW;
   localparam int DEPTH       = 64;
   localparam int IW          = $clog2(DEPTH);
   localparam int NUM_REQ     = 2000; // random requests after the fill
   localparam int STALL_MAX   = 200;  // cycles a handshake may hang
   localparam int MODE_INIT   = 0;
   localparam int MODE_RANDOM = 1;
   localparam int MODE_DRAIN  = 2;

   logic          clk;
   logic          nreset;
   logic          umi0_in_valid;   // writes
   logic [UW-1:0] umi0_in_packet;
   logic          umi0_in_ready;
   logic          umi1_in_valid;   // reads
   logic [UW-1:0] umi1_in_packet;
   logic          umi1_in_ready;
   logic          umi0_out_valid;  // responses
   logic [UW-1:0] umi0_out_packet;
   logic          umi0_out_ready;

   integer        seed;
   logic [DW-1:0] mem_model [DEPTH]; // what the memory should hold

   // expected responses, oldest first
   logic [DW-1:0]                 exp_data [$];
   logic [AW-1:0]                 exp_dst [$];
   logic [umi_pkg::SIZE_W-1:0]    exp_size [$];
   logic [umi_pkg::OPTIONS_W-1:0] exp_options [$];

   logic x0;  // write transfer at coming edge
   logic x1;  // read transfer at coming edge
   logic xo;  // response transfer at coming edge
   int   xfer_count;
   int   init_issued;
   int   issued;
   int   reads_done;
   int   stalled_writes; // writes taken while a response waited
   int   stall0;
   int   stall1;
   int   stall_out;
   bit   after_xfer;
   int   prev_ch;
   int   must_go;        // channel owed the next grant, -1 if none
   int   cycles;

   umi_ep_top #(.UW(UW), .AW(AW), .DW(DW), .DEPTH(DEPTH))
   dut_i (.clk             (clk),
          .nreset          (nreset),
          .umi0_in_valid   (umi0_in_valid),
          .umi0_in_packet  (umi0_in_packet),
          .umi0_in_ready   (umi0_in_ready),
          .umi1_in_valid   (umi1_in_valid),
          .umi1_in_packet  (umi1_in_packet),
          .umi1_in_ready   (umi1_in_ready),
          .umi0_out_valid  (umi0_out_valid),
          .umi0_out_packet (umi0_out_packet),
          .umi0_out_ready  (umi0_out_ready));

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   //####################################################################
   // helpers
   //####################################################################

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   // request packet, opcode and options random, source random
   function automatic logic [UW-1:0] make_request(input logic          write,
                                                  input logic [AW-1:0] dst,
                                                  input logic [DW-1:0] data);
      logic [UW-1:0] pkt;
      logic [31:0]   r;
      logic [31:0]   r_opt;
      r     = next_rand();
      r_opt = next_rand();
      pkt   = '0;
      pkt[umi_pkg::WRITE_BIT] = write;
      pkt[umi_pkg::OPCODE_MSB:umi_pkg::OPCODE_LSB]   = r[6:0]; // not decoded
      pkt[umi_pkg::SIZE_MSB:umi_pkg::SIZE_LSB]       = r[10:7];
      pkt[umi_pkg::OPTIONS_MSB:umi_pkg::OPTIONS_LSB] = r_opt[19:0];
      pkt[umi_pkg::DST_LSB +: AW]  = dst;
      pkt[umi_pkg::SRC_LSB +: AW]  = {next_rand(), next_rand()}; // return address
      pkt[umi_pkg::DATA_LSB +: DW] = data;
      return pkt;
   endfunction

   // 8 bytes per word, wraps at DEPTH
   function automatic int word_index(input logic [AW-1:0] addr);
      return int'((addr / 8) % DEPTH);
   endfunction

   task automatic stop_failed();
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_error(input string reason);
      $display("ERROR at %0t: %s", $time, reason);
      stop_failed();
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s got %h expected %h",
                  $time, name, actual, expected);
         stop_failed();
      end
   endtask

   //####################################################################
   // monitor, runs at the falling edge where everything is settled
   //####################################################################

   task automatic sample_cycle();
      logic [UW-1:0] pkt;
      int            ch;
      int            other;
      x0 = umi0_in_valid && umi0_in_ready;
      x1 = umi1_in_valid && umi1_in_ready;
      xo = umi0_out_valid && umi0_out_ready;
      // response valid exactly while something is owed
      check_value("umi0_out_valid", 64'(umi0_out_valid), 64'(exp_data.size() != 0));
      if (x0 && x1)
         report_error("both request channels were accepted in the same cycle");
      if (xo)
      begin
         pkt = umi0_out_packet;
         check_value("umi0_out_packet write bit", 64'(pkt[umi_pkg::WRITE_BIT]), 64'd1);
         check_value("umi0_out_packet opcode",
                     64'(pkt[umi_pkg::OPCODE_MSB:umi_pkg::OPCODE_LSB]),
                     64'(umi_pkg::RESP_OPCODE));
         check_value("umi0_out_packet size",
                     64'(pkt[umi_pkg::SIZE_MSB:umi_pkg::SIZE_LSB]), 64'(exp_size[0]));
         check_value("umi0_out_packet options",
                     64'(pkt[umi_pkg::OPTIONS_MSB:umi_pkg::OPTIONS_LSB]),
                     64'(exp_options[0]));
         check_value("umi0_out_packet dstaddr", 64'(pkt[umi_pkg::DST_LSB +: AW]), exp_dst[0]);
         check_value("umi0_out_packet srcaddr", 64'(pkt[umi_pkg::SRC_LSB +: AW]), 64'd0);
         check_value("umi0_out_packet data", 64'(pkt[umi_pkg::DATA_LSB +: DW]), exp_data[0]);
         void'(exp_data.pop_front());
         void'(exp_dst.pop_front());
         void'(exp_size.pop_front());
         void'(exp_options.pop_front());
         reads_done++;
      end
      if (x0)
      begin
         pkt = umi0_in_packet;
         mem_model[word_index(pkt[umi_pkg::DST_LSB +: AW])] = pkt[umi_pkg::DATA_LSB +: DW];
         if (umi0_out_valid && !umi0_out_ready)
            stalled_writes++;
      end
      if (x1)
      begin
         pkt = umi1_in_packet;
         exp_data.push_back(mem_model[word_index(pkt[umi_pkg::DST_LSB +: AW])]);
         exp_dst.push_back(pkt[umi_pkg::SRC_LSB +: AW]);     // reply to requester
         exp_size.push_back(pkt[umi_pkg::SIZE_MSB:umi_pkg::SIZE_LSB]);
         exp_options.push_back(pkt[umi_pkg::OPTIONS_MSB:umi_pkg::OPTIONS_LSB]);
      end
      // round robin, other channel valid right after a transfer wins next
      if (after_xfer)
      begin
         other = 1 - prev_ch;
         if ((other == 0 && umi0_in_valid) || (other == 1 && umi1_in_valid))
            must_go = other;
      end
      if (x0 || x1)
      begin
         ch = x1 ? 1 : 0;
         if (must_go >= 0)
            check_value("granted channel", 64'(ch), 64'(must_go));
         must_go    = -1;
         prev_ch    = ch;
         after_xfer = 1'b1;
         xfer_count++;
      end
      else
         after_xfer = 1'b0;
      // per handshake hang detection
      stall0    = (umi0_in_valid && !x0) ? stall0 + 1 : 0;
      stall1    = (umi1_in_valid && !x1) ? stall1 + 1 : 0;
      stall_out = (umi0_out_valid && !xo) ? stall_out + 1 : 0;
      if (stall0 > STALL_MAX)
         report_error("write request was not accepted in time");
      if (stall1 > STALL_MAX)
         report_error("read request was not accepted in time");
      if (stall_out > STALL_MAX)
         report_error("read response did not drain in time");
   endtask

   //####################################################################
   // stimulus, applied 2 ns after the rising edge
   //####################################################################

   task automatic drive_inputs(input int mode);
      logic [AW-1:0] addr;
      umi0_out_ready = (next_rand() % 100) < 70; // back-pressure ~30%
      // packet only moves when idle or just accepted
      if (!umi0_in_valid || x0)
      begin
         if (mode == MODE_INIT && init_issued < DEPTH)
         begin
            addr = {next_rand(), next_rand()};
            addr[3 +: IW] = init_issued[IW-1:0]; // walk every word once
            umi0_in_packet = make_request(1'b1, addr, {next_rand(), next_rand()});
            umi0_in_valid  = 1'b1;
            init_issued++;
         end
         else if (mode == MODE_RANDOM && issued < NUM_REQ && (next_rand() % 100) < 60)
         begin
            umi0_in_packet = make_request(1'b1, {next_rand(), next_rand()},
                                          {next_rand(), next_rand()});
            umi0_in_valid  = 1'b1;
            issued++;
         end
         else
            umi0_in_valid = 1'b0;
      end
      if (!umi1_in_valid || x1)
      begin
         if (mode == MODE_RANDOM && issued < NUM_REQ && (next_rand() % 100) < 60)
         begin
            umi1_in_packet = make_request(1'b0, {next_rand(), next_rand()}, '0);
            umi1_in_valid  = 1'b1;
            issued++;
         end
         else
            umi1_in_valid = 1'b0;
      end
   endtask

   task automatic step(input int mode);
      @(negedge clk);
      sample_cycle();
      @(posedge clk);
      #2;
      drive_inputs(mode);
   endtask

   //####################################################################
   // sequence
   //####################################################################

   initial
   begin
      seed           = 31;
      nreset         = 1'b0;
      umi0_in_valid  = 1'b0;
      umi0_in_packet = '0;
      umi1_in_valid  = 1'b0;
      umi1_in_packet = '0;
      umi0_out_ready = 1'b0;
      x0             = 1'b0;
      x1             = 1'b0;
      xo             = 1'b0;
      xfer_count     = 0;
      init_issued    = 0;
      issued         = 0;
      reads_done     = 0;
      stalled_writes = 0;
      stall0         = 0;
      stall1         = 0;
      stall_out      = 0;
      after_xfer     = 1'b0;
      prev_ch        = 0;
      must_go        = -1;
      repeat (10) @(posedge clk);
      #2;
      nreset = 1'b1;

      // fill every word so later reads have known data
      cycles = 0;
      while (xfer_count < DEPTH)
      begin
         if (cycles == DEPTH * 20)
            report_error("memory fill did not finish in time");
         step(MODE_INIT);
         cycles++;
      end

      // mixed traffic on both channels
      cycles = 0;
      while (xfer_count < DEPTH + NUM_REQ)
      begin
         if (cycles == NUM_REQ * 30)
            report_error("random traffic did not finish in time");
         step(MODE_RANDOM);
         cycles++;
      end

      // last responses out
      cycles = 0;
      while (exp_data.size() != 0)
      begin
         if (cycles == STALL_MAX)
            report_error("response queue did not drain in time");
         step(MODE_DRAIN);
         cycles++;
      end

      $display("%0d requests, %0d reads answered, %0d writes taken under a stall",
               NUM_REQ, reads_done, stalled_writes);
      if (stalled_writes == 0)
         report_error("no write was accepted while a response was stalled");
      else
      begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

// ==== umi_ep.f ====
hw/umi_pkg.sv
hw/umi_mux.sv
hw/umi_endpoint.sv
hw/umi_regfile.sv
hw/umi_ep_top.sv
testbench/umi_ep_assertions.sv
testbench/umi_ep_tb.sv
